// ==== source/adc_capture_pkg.sv ====
`default_nettype none

package adc_capture_pkg;

    // Width of one converter sample.
    localparam int ADC_W = 36;

    // Channels delivered per sample period.
    localparam int NUM_CH = 24;

    // Field widths of a test-pattern word, upper to lower.
    localparam int FCNT_W = 16;
    localparam int CHAN_W = 8;
    localparam int TAG_W = 12;

    // Marker in the low bits of every self-mode word.
    localparam logic [TAG_W-1:0] PATTERN_TAG = 12'h5A3;

    typedef logic [ADC_W-1:0] adc_word_t;

    // One full sample period, channel 0 in the lowest slot.
    typedef adc_word_t [NUM_CH-1:0] sample_set_t;

    // One word on the outgoing link.
    typedef struct packed {
        logic              sof;
        logic [CHAN_W-1:0] chan;
        adc_word_t         data;
    } stream_word_t;

endpackage

`default_nettype wire

// ==== source/test_pkt_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module test_pkt_gen #(
    parameter int NUM_CH = adc_capture_pkg::NUM_CH
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          sample_valid,
    output adc_capture_pkg::sample_set_t gen_data,
    output logic                         gen_valid
);

    import adc_capture_pkg::*;

    // Count of sample periods since reset, wraps silently.
    logic [FCNT_W-1:0] frame_cnt;

    // Builds the self-mode word of one channel.
    function automatic adc_word_t pattern_word(
        input logic [FCNT_W-1:0] cnt,
        input int                ch
    );
        adc_word_t word;
        word = {cnt, CHAN_W'(ch), PATTERN_TAG};
        return word;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_cnt <= '0;
            gen_valid <= 1'b0;
        end else begin
            gen_valid <= sample_valid;
            if (sample_valid) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

    // The set carries the count as it stood at the strobe, so the first
    // frame after reset shows zero.
    always_ff @(posedge clk) begin
        if (sample_valid) begin
            for (int ch = 0; ch < NUM_CH; ch++) begin
                gen_data[ch] <= pattern_word(frame_cnt, ch);
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/adc_data_sel.sv ====
`timescale 1ns/1ns
`default_nettype none

module adc_data_sel #(
    parameter int NUM_CH = adc_capture_pkg::NUM_CH
) (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               sample_valid,
    input  wire                               rf_self_mode,
    input  wire adc_capture_pkg::sample_set_t ana_adc_data,
    input  wire adc_capture_pkg::sample_set_t gen_data,
    input  wire                               gen_valid,
    output adc_capture_pkg::sample_set_t      sel_data,
    output logic                              sel_valid
);

    import adc_capture_pkg::*;

    logic        self_mode_q;
    sample_set_t ana_q;

    // Mode and analog set are captured on the same strobe that starts the
    // generator, so the choice below always concerns one sample period.
    always_ff @(posedge clk) begin
        if (rst) begin
            self_mode_q <= 1'b0;
        end else if (sample_valid) begin
            self_mode_q <= rf_self_mode;
        end
    end

    always_ff @(posedge clk) begin
        if (sample_valid) begin
            ana_q <= ana_adc_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_valid <= 1'b0;
        end else begin
            sel_valid <= gen_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (gen_valid) begin
            for (int ch = 0; ch < NUM_CH; ch++) begin
                sel_data[ch] <= self_mode_q ? gen_data[ch] : ana_q[ch];
            end
        end
    end

    // The generator must answer every strobe on the very next cycle.
    a_gen_after_strobe: assert property (@(posedge clk) disable iff (rst)
        sample_valid |=> gen_valid);
    a_gen_needs_strobe: assert property (@(posedge clk) disable iff (rst)
        gen_valid |-> $past(sample_valid));

endmodule

`default_nettype wire

// ==== source/chan_serializer.sv ====
`timescale 1ns/1ns
`default_nettype none

module chan_serializer #(
    parameter int NUM_CH = adc_capture_pkg::NUM_CH,
    parameter int CREDITS = 4
) (
    input  wire                               clk,
    input  wire                               rst,
    input  wire adc_capture_pkg::sample_set_t sel_data,
    input  wire                               sel_valid,
    input  wire                               credit_return,
    output logic                              out_valid,
    output adc_capture_pkg::stream_word_t     out_word,
    output logic                              overrun
);

    import adc_capture_pkg::*;

    localparam int CNT_W = $clog2(CREDITS + 1);
    localparam logic [CHAN_W-1:0] LAST_CH = CHAN_W'(NUM_CH - 1);
    localparam logic [CNT_W-1:0] FULL_CREDIT = CNT_W'(CREDITS);

    sample_set_t       frame_buf;
    logic [CHAN_W-1:0] chan_idx;
    logic              busy;
    logic [CNT_W-1:0]  credit_cnt;
    logic              accept;
    logic              last_word;

    // A new set is taken only between frames.
    assign accept = sel_valid && !busy;

    assign out_valid = busy && (credit_cnt != '0);
    assign last_word = out_valid && (chan_idx == LAST_CH);

    // The word follows the channel index, so it holds while credit is out.
    assign out_word.sof = (chan_idx == '0);
    assign out_word.chan = chan_idx;
    assign out_word.data = frame_buf[chan_idx];

    always_ff @(posedge clk) begin
        if (accept) begin
            frame_buf <= sel_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            chan_idx <= '0;
        end else begin
            if (accept) begin
                busy <= 1'b1;
            end else if (last_word) begin
                busy <= 1'b0;
            end

            if (last_word) begin
                chan_idx <= '0;
            end else if (out_valid) begin
                chan_idx <= chan_idx + 1'b1;
            end
        end
    end

    // Sticky until reset. A set arriving during the last word is dropped too.
    always_ff @(posedge clk) begin
        if (rst) begin
            overrun <= 1'b0;
        end else if (sel_valid && busy) begin
            overrun <= 1'b1;
        end
    end

    // One credit is spent per word sent and one comes back per return pulse.
    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= FULL_CREDIT;
        end else begin
            case ({out_valid, credit_return})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    a_credit_bound: assert property (@(posedge clk) disable iff (rst)
        credit_cnt <= FULL_CREDIT);

    // The receiver must not return credit for a word it never got.
    a_return_owed: assert property (@(posedge clk) disable iff (rst)
        credit_return |-> (credit_cnt < FULL_CREDIT) || out_valid);

    // Once dry, nothing goes out until a credit has come back.
    a_no_send_dry: assert property (@(posedge clk) disable iff (rst)
        (credit_cnt == '0 && !credit_return) |=> !out_valid);

endmodule

`default_nettype wire

// ==== source/adc_capture_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module adc_capture_top #(
    parameter int NUM_CH = adc_capture_pkg::NUM_CH,
    parameter int CREDITS = 4
) (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               rf_self_mode,
    input  wire                               sample_valid,
    input  wire adc_capture_pkg::sample_set_t ana_adc_data,
    input  wire                               credit_return,
    output logic                              out_valid,
    output adc_capture_pkg::stream_word_t     out_word,
    output logic                              overrun
);

    import adc_capture_pkg::*;

    sample_set_t gen_data;
    logic        gen_valid;
    sample_set_t sel_data;
    logic        sel_valid;

    test_pkt_gen #(
        .NUM_CH(NUM_CH)
    ) u_test_pkt_gen (
        .clk          (clk),
        .rst          (rst),
        .sample_valid (sample_valid),
        .gen_data     (gen_data),
        .gen_valid    (gen_valid)
    );

    // Analog words are held inside the selector for one cycle to meet the
    // generated set.
    adc_data_sel #(
        .NUM_CH(NUM_CH)
    ) u_adc_data_sel (
        .clk          (clk),
        .rst          (rst),
        .sample_valid (sample_valid),
        .rf_self_mode (rf_self_mode),
        .ana_adc_data (ana_adc_data),
        .gen_data     (gen_data),
        .gen_valid    (gen_valid),
        .sel_data     (sel_data),
        .sel_valid    (sel_valid)
    );

    chan_serializer #(
        .NUM_CH  (NUM_CH),
        .CREDITS (CREDITS)
    ) u_chan_serializer (
        .clk           (clk),
        .rst           (rst),
        .sel_data      (sel_data),
        .sel_valid     (sel_valid),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_word      (out_word),
        .overrun       (overrun)
    );

endmodule

`default_nettype wire

// ==== verification/adc_capture_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module adc_capture_tb;

    import adc_capture_pkg::*;

    localparam int CREDITS = 4;
    localparam int RET_DELAY = 3;
    localparam int WAIT_LIMIT = 2000;

    logic         clk;
    logic         rst;
    logic         rf_self_mode;
    logic         sample_valid;
    sample_set_t  ana_adc_data;
    logic         credit_return;
    logic         out_valid;
    stream_word_t out_word;
    logic         overrun;

    integer seed;
    int     strobe_cnt;
    int     cycle;
    int     in_flight;
    int     words_seen;
    bit     stall;
    bit     drop_issued;
    bit     overrun_seen;

    // Words the DUT still owes, oldest first.
    stream_word_t exp_q[$];
    // Cycle from which each received word may give its credit back.
    int           ret_due_q[$];

    adc_capture_top u_adc_capture_top (
        .clk           (clk),
        .rst           (rst),
        .rf_self_mode  (rf_self_mode),
        .sample_valid  (sample_valid),
        .ana_adc_data  (ana_adc_data),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_word      (out_word),
        .overrun       (overrun)
    );

    always #5 clk = ~clk;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    function automatic sample_set_t random_set();
        sample_set_t set;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            set[ch] = ADC_W'({$random(seed), $random(seed)});
        end
        return set;
    endfunction

    // Self-mode words carry the strobe count, the channel and the tag.
    function automatic stream_word_t expected_word(input bit self_mode, input sample_set_t ana,
                                                   input int ch, input int cnt);
        stream_word_t w;
        w.sof = (ch == 0);
        w.chan = CHAN_W'(ch);
        if (self_mode) begin
            w.data = {FCNT_W'(cnt), CHAN_W'(ch), PATTERN_TAG};
        end else begin
            w.data = ana[ch];
        end
        return w;
    endfunction

    task automatic issue_strobe(input bit self_mode, input bit expect_drop);
        sample_set_t set;
        set = random_set();
        @(posedge clk);
        sample_valid <= 1'b1;
        rf_self_mode <= self_mode;
        ana_adc_data <= set;
        if (expect_drop) begin
            drop_issued = 1'b1;
        end else begin
            for (int ch = 0; ch < NUM_CH; ch++) begin
                exp_q.push_back(expected_word(self_mode, set, ch, strobe_cnt));
            end
        end
        strobe_cnt++;
        @(posedge clk);
        // Mode and analog words change right after the strobe, so only the
        // copies latched on the strobe can give the right frame.
        sample_valid <= 1'b0;
        rf_self_mode <= !self_mode;
        ana_adc_data <= random_set();
    endtask

    // Mode and analog inputs wander while the frame drains; only strobes count.
    task automatic wait_frame_done();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            rf_self_mode <= 1'($random(seed));
            ana_adc_data <= random_set();
            n++;
            if (n > WAIT_LIMIT) begin
                stop_with_error("Timeout waiting for a frame to finish");
            end
        end
    endtask

    task automatic wait_until_dry();
        int n;
        n = 0;
        while (in_flight < CREDITS) begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                stop_with_error("Timeout waiting for the link credit to run out");
            end
        end
    endtask

    task automatic wait_for_overrun();
        int n;
        n = 0;
        while (!overrun) begin
            @(posedge clk);
            n++;
            if (n > 50) begin
                stop_with_error("Overrun flag did not rise after a strobe during a busy frame");
            end
        end
    endtask

    task automatic wait_credit_home();
        int n;
        n = 0;
        while (in_flight != 0) begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                stop_with_error("Timeout waiting for all credits to come back");
            end
        end
    endtask

    // Output checker and credit return model.
    always @(posedge clk) begin
        stream_word_t exp_w;
        if (rst) begin
            assert (!out_valid && !overrun)
                else stop_with_error("Output valid or overrun active during reset");
            credit_return <= 1'b0;
        end else begin
            if (out_valid) begin
                words_seen++;
                if (exp_q.size() == 0) begin
                    stop_with_error($sformatf("Word for channel %0d sent with no frame pending",
                                              out_word.chan));
                end else begin
                    exp_w = exp_q.pop_front();
                    assert (out_word == exp_w)
                        else stop_with_error($sformatf(
                            "Mismatch at %0t: got chan %0d sof %0b %h, exp chan %0d sof %0b %h",
                            $time, out_word.chan, out_word.sof, out_word.data,
                            exp_w.chan, exp_w.sof, exp_w.data));
                    ret_due_q.push_back(cycle + RET_DELAY);
                end
            end
            in_flight = in_flight + int'(out_valid) - int'(credit_return);
            assert (in_flight <= CREDITS)
                else stop_with_error("More words in flight than the link has credits");
            if (!drop_issued) begin
                assert (!overrun) else stop_with_error("Overrun set with no dropped strobe");
            end
            if (overrun_seen) begin
                assert (overrun) else stop_with_error("Overrun flag cleared without a reset");
            end
            overrun_seen = overrun_seen || overrun;
            if (!stall && ret_due_q.size() != 0 && ret_due_q[0] <= cycle) begin
                void'(ret_due_q.pop_front());
                credit_return <= 1'b1;
            end else begin
                credit_return <= 1'b0;
            end
            cycle++;
        end
    end

    initial begin
        int frozen;
        clk = 1'b0;
        rst = 1'b1;
        rf_self_mode = 1'b0;
        sample_valid = 1'b0;
        ana_adc_data = '0;
        credit_return = 1'b0;
        seed = 32'h6870f103;
        strobe_cnt = 0;
        cycle = 0;
        in_flight = 0;
        words_seen = 0;
        stall = 1'b0;
        drop_issued = 1'b0;
        overrun_seen = 1'b0;

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);

        for (int i = 0; i < 3; i++) begin
            issue_strobe(1'b0, 1'b0);
            wait_frame_done();
        end
        for (int i = 0; i < 3; i++) begin
            issue_strobe(1'b1, 1'b0);
            wait_frame_done();
        end
        for (int i = 0; i < 6; i++) begin
            issue_strobe(1'($random(seed)), 1'b0);
            wait_frame_done();
        end

        // With returns withheld the frame freezes partway through.
        stall = 1'b1;
        issue_strobe(1'b0, 1'b0);
        wait_until_dry();
        repeat (3) @(posedge clk);
        frozen = words_seen;
        repeat (12) @(posedge clk);
        assert (words_seen == frozen)
            else stop_with_error("Stream kept running with no credit left");

        // This set lands on a busy serializer and must vanish.
        issue_strobe(1'b1, 1'b1);
        wait_for_overrun();
        stall = 1'b0;
        wait_frame_done();
        for (int i = 0; i < 2; i++) begin
            issue_strobe(1'b1, 1'b0);
            wait_frame_done();
        end
        wait_credit_home();
        repeat (20) @(posedge clk);

        if (exp_q.size() != 0 || !overrun) begin
            stop_with_error("Frames left unsent or overrun flag lost at the end of the run");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== adc_capture_top.f ====
source/adc_capture_pkg.sv
source/test_pkt_gen.sv
source/adc_data_sel.sv
source/chan_serializer.sv
source/adc_capture_top.sv
verification/adc_capture_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compiles the capture front end with its testbench under Verilator and runs it.
# Exits non-zero unless the simulation log reports success.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=adc_capture_sim
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/1ns \
    --top-module adc_capture_tb \
    -f adc_capture_top.f \
    --Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All checks passed" "$LOG_FILE"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation did not pass, see $LOG_FILE"
    exit 1
fi
